/* verilog/ide_pkg.sv */
`default_nettype none

package ide_pkg;

  // --------------------------------------------------------------------------
  // bus widths
  // --------------------------------------------------------------------------

  // ide data bus width
  localparam int IDE_DW = 16;

  // --------------------------------------------------------------------------
  // access decode
  // --------------------------------------------------------------------------

  // target block of one access
  typedef enum logic [1:0] {
    // unmapped, answered by the host
    CS_NONE = 2'b00,
    // command block via ncs1fx
    CS_CMD  = 2'b01,
    // control block via ncs3fx
    CS_CTL  = 2'b10
  } ide_cs_e;

  // byte lanes taken from wb_sel_i
  typedef enum logic [1:0] {
    LANE_WORD = 2'b00,
    LANE_LOW  = 2'b01,
    LANE_HIGH = 2'b10
  } ide_lane_e;

  // --------------------------------------------------------------------------
  // host to sequencer request
  // --------------------------------------------------------------------------

  // one pio access, 22 bits
  typedef struct packed {
    // device address da[2:0]
    logic [2:0]        da;
    ide_cs_e           cs;
    logic              we;
    // write data, already on the ide lanes
    logic [IDE_DW-1:0] wdata;
  } ide_req_t;

endpackage

`default_nettype wire

/* verilog/ide_wb_host.sv */
`timescale 1ns/1ps
`default_nettype none

module ide_wb_host (
  input  wire                          wb_clk_i,
  input  wire                          wb_rst_i,
  input  wire                          wb_stb_i,
  input  wire                          wb_cyc_i,
  input  wire  [19:1]                  wb_adr_i,
  input  wire                          wb_we_i,
  input  wire  [1:0]                   wb_sel_i,
  input  wire  [15:0]                  wb_dat_i,
  output logic [15:0]                  wb_dat_o,
  output logic                         wb_ack_o,
  output logic                         wb_tgc_o,
  input  wire                          ide_intrq_i,
  output logic                         pio_start_o,
  output ide_pkg::ide_req_t            pio_req_o,
  input  wire                          pio_done_i,
  input  wire  [ide_pkg::IDE_DW-1:0]   pio_rdata_i
);

  // --------------------------------------------------------------------------
  // access detect and decode
  // --------------------------------------------------------------------------

  // set from recognition until the ack cycle
  logic                  busy_q;
  // new access, first cycle only
  logic                  new_acc;
  ide_pkg::ide_cs_e      cs_dec;
  ide_pkg::ide_lane_e    lane_dec;
  logic [15:0]           wdata_dec;
  // lane kept for the read return
  ide_pkg::ide_lane_e    lane_q;
  logic [15:0]           rdata_steer;
  // interrupt synchronizer
  logic [1:0]            intrq_sync_q;

  assign new_acc = wb_stb_i & wb_cyc_i & ~busy_q;

  // bit 9 low is command block
  // bit 9 high needs bits 2:1 both set for the control block
  always_comb
  begin
    if (!wb_adr_i[9])
      cs_dec = ide_pkg::CS_CMD;
    else if (wb_adr_i[2:1] == 2'b11)
      cs_dec = ide_pkg::CS_CTL;
    else
      cs_dec = ide_pkg::CS_NONE;
  end

  // lane from byte selects
  always_comb
  begin
    case (wb_sel_i)
      2'b01:   lane_dec = ide_pkg::LANE_LOW;
      2'b10:   lane_dec = ide_pkg::LANE_HIGH;
      default: lane_dec = ide_pkg::LANE_WORD;
    endcase
  end

  // single byte always goes out on dd[7:0]
  always_comb
  begin
    case (lane_dec)
      ide_pkg::LANE_LOW:  wdata_dec = {8'h00, wb_dat_i[7:0]};
      ide_pkg::LANE_HIGH: wdata_dec = {8'h00, wb_dat_i[15:8]};
      default:            wdata_dec = wb_dat_i;
    endcase
  end

  // --------------------------------------------------------------------------
  // request capture
  // --------------------------------------------------------------------------

  always_ff @(posedge wb_clk_i)
  begin
    if (new_acc)
    begin
      // odd byte select gives da[0]
      pio_req_o.da    <= {wb_adr_i[2:1], (wb_sel_i == 2'b10)};
      pio_req_o.cs    <= cs_dec;
      pio_req_o.we    <= wb_we_i;
      pio_req_o.wdata <= wdata_dec;
      lane_q          <= lane_dec;
    end
  end

  // --------------------------------------------------------------------------
  // handshake
  // --------------------------------------------------------------------------

  // start and ack are single cycle pulses
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      busy_q      <= 1'b0;
      pio_start_o <= 1'b0;
      wb_ack_o    <= 1'b0;
    end
    else
    begin
      pio_start_o <= 1'b0;
      wb_ack_o    <= 1'b0;
      if (new_acc)
      begin
        busy_q <= 1'b1;
        // unmapped space is acked here, no ide cycle
        if (cs_dec == ide_pkg::CS_NONE)
          wb_ack_o <= 1'b1;
        else
          pio_start_o <= 1'b1;
      end
      else if (busy_q && pio_done_i)
        wb_ack_o <= 1'b1;
      // master drops stb after seeing ack
      if (wb_ack_o)
        busy_q <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // read return
  // --------------------------------------------------------------------------

  // byte reads come back on dd[7:0]
  always_comb
  begin
    case (lane_q)
      ide_pkg::LANE_LOW:  rdata_steer = {8'h00, pio_rdata_i[7:0]};
      ide_pkg::LANE_HIGH: rdata_steer = {pio_rdata_i[7:0], 8'h00};
      default:            rdata_steer = pio_rdata_i;
    endcase
  end

  // held until the next ack
  always_ff @(posedge wb_clk_i)
  begin
    if (new_acc && (cs_dec == ide_pkg::CS_NONE))
      wb_dat_o <= 16'h0000;
    else if (busy_q && pio_done_i)
      wb_dat_o <= rdata_steer;
  end

  // --------------------------------------------------------------------------
  // interrupt
  // --------------------------------------------------------------------------

  // intrq is async to wb_clk_i, two flops
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      intrq_sync_q <= 2'b00;
    else
      intrq_sync_q <= {intrq_sync_q[0], ide_intrq_i};
  end

  assign wb_tgc_o = intrq_sync_q[1];

endmodule

`default_nettype wire

/* verilog/ide_pio_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module ide_pio_sequencer #(
  parameter int SETUP_CYCLES      = 2,
  parameter int MIN_STROBE_CYCLES = 3
) (
  input  wire                          wb_clk_i,
  input  wire                          wb_rst_i,
  input  wire                          pio_start_i,
  input  wire ide_pkg::ide_req_t       pio_req_i,
  output logic                         pio_done_o,
  output logic [ide_pkg::IDE_DW-1:0]   pio_rdata_o,
  output logic [2:0]                   ide_da_o,
  output logic                         ide_ncs1fx_o,
  output logic                         ide_ncs3fx_o,
  output logic                         ide_ndior_o,
  output logic                         ide_ndiow_o,
  output logic                         ide_nreset_o,
  inout  wire  [ide_pkg::IDE_DW-1:0]   ide_dd_io,
  input  wire                          ide_iordy_i
);

  // --------------------------------------------------------------------------
  // counter sizing
  // --------------------------------------------------------------------------

  // one counter covers setup and strobe phases
  localparam int CNT_MAX = (SETUP_CYCLES > MIN_STROBE_CYCLES) ?
                           SETUP_CYCLES : MIN_STROBE_CYCLES;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  // reload values, count down to zero
  localparam logic [CNT_W-1:0] SETUP_LOAD  = CNT_W'(SETUP_CYCLES - 1);
  localparam logic [CNT_W-1:0] STROBE_LOAD = CNT_W'(MIN_STROBE_CYCLES - 1);

  typedef enum logic [1:0] {
    ST_IDLE    = 2'b00,
    // address and cs valid, strobe high
    ST_SETUP   = 2'b01,
    // dior or diow low
    ST_STROBE  = 2'b10,
    // strobe high again, cs still low
    ST_RELEASE = 2'b11
  } seq_state_e;

  seq_state_e          state_q;
  logic [CNT_W-1:0]    cnt_q;
  ide_pkg::ide_req_t   req_q;
  // data bus output enable
  logic                oe_q;
  // start accepted this cycle
  logic                start_ok;
  // closing edge of the strobe
  logic                strobe_end;

  assign start_ok   = (state_q == ST_IDLE) && pio_start_i;
  // min width reached and device ready
  assign strobe_end = (state_q == ST_STROBE) && (cnt_q == '0) && ide_iordy_i;

  // --------------------------------------------------------------------------
  // request register
  // --------------------------------------------------------------------------

  always_ff @(posedge wb_clk_i)
  begin
    if (start_ok)
      req_q <= pio_req_i;
  end

  // da straight from the captured request
  assign ide_da_o = req_q.da;

  // --------------------------------------------------------------------------
  // pio fsm
  // --------------------------------------------------------------------------

  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      state_q      <= ST_IDLE;
      cnt_q        <= '0;
      ide_ncs1fx_o <= 1'b1;
      ide_ncs3fx_o <= 1'b1;
      ide_ndior_o  <= 1'b1;
      ide_ndiow_o  <= 1'b1;
      oe_q         <= 1'b0;
      pio_done_o   <= 1'b0;
    end
    else
    begin
      // done is a single pulse
      pio_done_o <= 1'b0;
      case (state_q)
        ST_IDLE:
        begin
          if (pio_start_i)
          begin
            // cs goes low together with da
            ide_ncs1fx_o <= (pio_req_i.cs != ide_pkg::CS_CMD);
            ide_ncs3fx_o <= (pio_req_i.cs != ide_pkg::CS_CTL);
            // write data driven through setup
            oe_q         <= pio_req_i.we;
            cnt_q        <= SETUP_LOAD;
            state_q      <= ST_SETUP;
          end
        end
        ST_SETUP:
        begin
          if (cnt_q == '0)
          begin
            ide_ndiow_o <= ~req_q.we;
            ide_ndior_o <= req_q.we;
            cnt_q       <= STROBE_LOAD;
            state_q     <= ST_STROBE;
          end
          else
            cnt_q <= cnt_q - 1'b1;
        end
        ST_STROBE:
        begin
          // counter holds at zero while iordy is low
          if (cnt_q != '0)
            cnt_q <= cnt_q - 1'b1;
          else if (ide_iordy_i)
          begin
            ide_ndior_o <= 1'b1;
            ide_ndiow_o <= 1'b1;
            pio_done_o  <= 1'b1;
            state_q     <= ST_RELEASE;
          end
        end
        default:
        begin
          // hold time after strobe rise
          ide_ncs1fx_o <= 1'b1;
          ide_ncs3fx_o <= 1'b1;
          oe_q         <= 1'b0;
          state_q      <= ST_IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // data bus
  // --------------------------------------------------------------------------

  assign ide_dd_io = oe_q ? req_q.wdata : {ide_pkg::IDE_DW{1'bz}};

  // sample on the edge that raises dior
  // kept until the next read closes
  always_ff @(posedge wb_clk_i)
  begin
    if (strobe_end)
      pio_rdata_o <= ide_dd_io;
  end

  // --------------------------------------------------------------------------
  // device reset
  // --------------------------------------------------------------------------

  // follows bus reset, one flop late
  always_ff @(posedge wb_clk_i)
  begin
    ide_nreset_o <= ~wb_rst_i;
  end

endmodule

`default_nettype wire

/* verilog/ide_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ide_ctrl_top #(
  parameter int SETUP_CYCLES      = 2,
  parameter int MIN_STROBE_CYCLES = 3
) (
  // wishbone slave
  input  wire                          wb_clk_i,
  input  wire                          wb_rst_i,
  input  wire                          wb_stb_i,
  input  wire                          wb_cyc_i,
  input  wire  [19:1]                  wb_adr_i,
  input  wire                          wb_we_i,
  input  wire  [1:0]                   wb_sel_i,
  input  wire  [15:0]                  wb_dat_i,
  output logic [15:0]                  wb_dat_o,
  output logic                         wb_ack_o,
  output logic                         wb_tgc_o,
  // ide device pins
  output logic [2:0]                   ide_da_o,
  output logic                         ide_ncs1fx_o,
  output logic                         ide_ncs3fx_o,
  output logic                         ide_ndior_o,
  output logic                         ide_ndiow_o,
  output logic                         ide_nreset_o,
  output logic                         ide_ndmack_o,
  inout  wire  [ide_pkg::IDE_DW-1:0]   ide_dd_io,
  input  wire                          ide_iordy_i,
  input  wire                          ide_intrq_i,
  // dma request, ignored in pio only mode
  input  wire                          ide_dmarq_i
);

  // --------------------------------------------------------------------------
  // host to sequencer
  // --------------------------------------------------------------------------

  logic                          pio_start;
  ide_pkg::ide_req_t             pio_req;
  logic                          pio_done;
  logic [ide_pkg::IDE_DW-1:0]    pio_rdata;

  // wishbone decode, lane steering, irq sync
  ide_wb_host u_host (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .wb_stb_i    (wb_stb_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_adr_i    (wb_adr_i),
    .wb_we_i     (wb_we_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_tgc_o    (wb_tgc_o),
    .ide_intrq_i (ide_intrq_i),
    .pio_start_o (pio_start),
    .pio_req_o   (pio_req),
    .pio_done_i  (pio_done),
    .pio_rdata_i (pio_rdata)
  );

  // pio cycle timing on the device side
  ide_pio_sequencer #(
    .SETUP_CYCLES      (SETUP_CYCLES),
    .MIN_STROBE_CYCLES (MIN_STROBE_CYCLES)
  ) u_seq (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .pio_start_i  (pio_start),
    .pio_req_i    (pio_req),
    .pio_done_o   (pio_done),
    .pio_rdata_o  (pio_rdata),
    .ide_da_o     (ide_da_o),
    .ide_ncs1fx_o (ide_ncs1fx_o),
    .ide_ncs3fx_o (ide_ncs3fx_o),
    .ide_ndior_o  (ide_ndior_o),
    .ide_ndiow_o  (ide_ndiow_o),
    .ide_nreset_o (ide_nreset_o),
    .ide_dd_io    (ide_dd_io),
    .ide_iordy_i  (ide_iordy_i)
  );

  // no dma, acknowledge stays inactive
  assign ide_ndmack_o = 1'b1;

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  // free running clock
  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released on a clock edge, seen low from the next one
  initial
  begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

/* testbench/ata_device_model.sv */
`timescale 1ns/1ps
`default_nettype none

module ata_device_model (
  input  wire         clk_i,
  input  wire  [2:0]  ide_da_i,
  input  wire         ide_ncs1fx_i,
  input  wire         ide_ncs3fx_i,
  input  wire         ide_ndior_i,
  input  wire         ide_ndiow_i,
  input  wire         ide_nreset_i,
  inout  wire  [15:0] ide_dd_io,
  output logic        ide_iordy_o,
  output logic        ide_intrq_o,
  // iordy low time per strobe, in clocks
  input  wire  [2:0]  wait_cycles_i,
  input  wire         intrq_i
);

  // command and control register files
  logic [15:0] cmd_regs [8];
  logic [15:0] ctl_regs [8];
  logic [15:0] rd_word;
  // clocks since the strobe fell
  int          low_cnt = 0;

  // ------------------------------------------------------------------------
  // register access
  // ------------------------------------------------------------------------

  // store what the bus shows when diow rises
  always @(posedge ide_ndiow_i)
  begin
    if (ide_nreset_i)
    begin
      if (!ide_ncs1fx_i)
        cmd_regs[ide_da_i] <= ide_dd_io;
      else if (!ide_ncs3fx_i)
        ctl_regs[ide_da_i] <= ide_dd_io;
    end
  end

  assign rd_word   = !ide_ncs1fx_i ? cmd_regs[ide_da_i] : ctl_regs[ide_da_i];
  // drive only while dior is low
  assign ide_dd_io = !ide_ndior_i ? rd_word : 16'hzzzz;

  // ------------------------------------------------------------------------
  // iordy wait insertion
  // ------------------------------------------------------------------------

  always @(posedge clk_i)
  begin
    if (!ide_ndior_i || !ide_ndiow_i)
      low_cnt <= low_cnt + 1;
    else
      low_cnt <= 0;
  end

  // ready once the wait count has passed
  assign ide_iordy_o = (ide_ndior_i && ide_ndiow_i) || (low_cnt >= int'(wait_cycles_i));

  // interrupt straight from the testbench
  assign ide_intrq_o = intrq_i;

endmodule

`default_nettype wire

/* testbench/ide_ctrl_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module ide_ctrl_properties (
  input wire       clk_i,
  input wire       rst_i,
  input wire       ack_i,
  input wire       ndior_i,
  input wire       ndiow_i,
  input wire       ncs1fx_i,
  input wire       ncs3fx_i,
  input wire [2:0] da_i,
  // sequencer data bus enable
  input wire       dd_oe_i
);

  // count of assertion failures
  int  fail_cnt = 0;
  wire strobe_low;

  assign strobe_low = !ndior_i || !ndiow_i;

  // never read and write at once
  strobe_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(!ndior_i && !ndiow_i))
  else
  begin
    fail_cnt++;
    $error("dior and diow are low together");
  end

  // address and selects frozen under the strobe
  addr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    strobe_low |-> $stable(da_i) && $stable(ncs1fx_i) && $stable(ncs3fx_i))
  else
  begin
    fail_cnt++;
    $error("device address or chip select changed while a strobe was low");
  end

  // write data only inside the selected, non-read window
  bus_window: assert property (@(posedge clk_i) disable iff (rst_i)
    dd_oe_i |-> (!ncs1fx_i || !ncs3fx_i) && ndior_i)
  else
  begin
    fail_cnt++;
    $error("data bus driven outside the write window");
  end

  ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i |=> !ack_i)
  else
  begin
    fail_cnt++;
    $error("wb_ack_o high for two cycles");
  end

  // exactly one block selected
  one_cs: assert property (@(posedge clk_i) disable iff (rst_i)
    strobe_low |-> (ncs1fx_i ^ ncs3fx_i))
  else
  begin
    fail_cnt++;
    $error("strobe without exactly one chip select low");
  end

endmodule

bind ide_ctrl_top ide_ctrl_properties u_props (
  .clk_i    (wb_clk_i),
  .rst_i    (wb_rst_i),
  .ack_i    (wb_ack_o),
  .ndior_i  (ide_ndior_o),
  .ndiow_i  (ide_ndiow_o),
  .ncs1fx_i (ide_ncs1fx_o),
  .ncs3fx_i (ide_ncs3fx_o),
  .da_i     (ide_da_o),
  .dd_oe_i  (u_seq.oe_q)
);

`default_nettype wire

/* testbench/tb_ide_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ide_ctrl;

  localparam int SETUP_CYCLES      = 2;
  localparam int MIN_STROBE_CYCLES = 3;
  // strobe recognition to ack with iordy high
  localparam int PIO_LATENCY       = 1 + 1 + SETUP_CYCLES + MIN_STROBE_CYCLES + 1;

  logic        clk;
  logic        rst;
  logic        wb_stb;
  logic        wb_cyc;
  logic [19:1] wb_adr;
  logic        wb_we;
  logic [1:0]  wb_sel;
  logic [15:0] wb_dat_w;
  wire  [15:0] wb_dat_r;
  wire         wb_ack;
  wire         wb_tgc;
  wire  [2:0]  ide_da;
  wire         ncs1fx;
  wire         ncs3fx;
  wire         ndior;
  wire         ndiow;
  wire         nreset;
  wire         ndmack;
  wire  [15:0] ide_dd;
  wire         iordy;
  wire         intrq;
  logic        dmarq;
  logic [2:0]  dev_wait;
  logic        dev_intrq;

  int          seed = 38;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          last_latency = 0;
  logic        hung = 1'b0;
  // strobe monitor
  int          low_run = 0;
  int          strobe_cnt = 0;
  int          last_width = 0;
  logic [2:0]  last_da = 3'b000;
  logic        last_cs3 = 1'b0;

  tb_clk_gen u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  ide_ctrl_top #(
    .SETUP_CYCLES      (SETUP_CYCLES),
    .MIN_STROBE_CYCLES (MIN_STROBE_CYCLES)
  ) u_dut (
    .wb_clk_i     (clk),
    .wb_rst_i     (rst),
    .wb_stb_i     (wb_stb),
    .wb_cyc_i     (wb_cyc),
    .wb_adr_i     (wb_adr),
    .wb_we_i      (wb_we),
    .wb_sel_i     (wb_sel),
    .wb_dat_i     (wb_dat_w),
    .wb_dat_o     (wb_dat_r),
    .wb_ack_o     (wb_ack),
    .wb_tgc_o     (wb_tgc),
    .ide_da_o     (ide_da),
    .ide_ncs1fx_o (ncs1fx),
    .ide_ncs3fx_o (ncs3fx),
    .ide_ndior_o  (ndior),
    .ide_ndiow_o  (ndiow),
    .ide_nreset_o (nreset),
    .ide_ndmack_o (ndmack),
    .ide_dd_io    (ide_dd),
    .ide_iordy_i  (iordy),
    .ide_intrq_i  (intrq),
    .ide_dmarq_i  (dmarq)
  );

  ata_device_model u_dev (
    .clk_i         (clk),
    .ide_da_i      (ide_da),
    .ide_ncs1fx_i  (ncs1fx),
    .ide_ncs3fx_i  (ncs3fx),
    .ide_ndior_i   (ndior),
    .ide_ndiow_i   (ndiow),
    .ide_nreset_i  (nreset),
    .ide_dd_io     (ide_dd),
    .ide_iordy_o   (iordy),
    .ide_intrq_o   (intrq),
    .wait_cycles_i (dev_wait),
    .intrq_i       (dev_intrq)
  );

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------

  // strobe width and address sampled on the falling edge
  always @(negedge clk)
  begin
    if (!ndior || !ndiow)
    begin
      if (low_run == 0)
      begin
        strobe_cnt++;
        last_da  = ide_da;
        last_cs3 = !ncs3fx;
      end
      low_run++;
    end
    else if (low_run != 0)
    begin
      last_width = low_run;
      low_run    = 0;
    end
  end

  // a hung bus ends the run here
  always @(posedge hung)
  begin
    $display("Regression failed");
    $finish;
  end

  task automatic check_eq(input string what, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp)
    else
    begin
      $display("Error at %0d ns: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_cond(input string what, input logic ok);
    assert (ok)
    else
    begin
      $display("Error at %0d ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errs_at_start);
    end
  endtask

  // one classic wishbone cycle started 1 ns after a rising edge
  task automatic bus_cycle(input logic we, input logic [19:1] adr, input logic [1:0] sel,
                           input logic [15:0] wdat, output logic [15:0] rdat);
    int waited;
    waited   = 0;
    wb_stb   = 1'b1;
    wb_cyc   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_sel   = sel;
    wb_dat_w = wdat;
    do
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    while (!wb_ack && waited < 200);
    rdat         = wb_dat_r;
    last_latency = waited;
    wb_stb       = 1'b0;
    wb_cyc       = 1'b0;
    wb_we        = 1'b0;
    if (!wb_ack)
    begin
      $display("bus cycle to %h got no acknowledge within 200 cycles", adr);
      hung = 1'b1;
    end
    // stb low for one cycle
    @(posedge clk);
    #1;
  endtask

  // ------------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------------

  initial
  begin
    logic [15:0] rd;
    logic [15:0] wr;
    logic [15:0] words [4];
    logic [19:1] a;
    int          t0;
    int          n;
    wb_stb    = 1'b0;
    wb_cyc    = 1'b0;
    wb_adr    = '0;
    wb_we     = 1'b0;
    wb_sel    = 2'b00;
    wb_dat_w  = 16'h0000;
    dmarq     = 1'b0;
    dev_wait  = 3'd0;
    dev_intrq = 1'b0;

    // reset state
    t0 = errors;
    repeat (2) @(posedge clk);
    #1;
    check_cond("strobes or chip selects low in reset", ndior && ndiow && ncs1fx && ncs3fx);
    check_cond("wb_ack_o or wb_tgc_o high in reset", !wb_ack && !wb_tgc);
    check_cond("ide_nreset_o high in reset", !nreset);
    check_cond("ide_ndmack_o low", ndmack);
    n = 0;
    while (rst && n < 20)
    begin
      @(posedge clk);
      #1;
      n++;
    end
    if (rst)
    begin
      $display("reset was never released");
      hung = 1'b1;
    end
    @(posedge clk);
    #1;
    check_cond("ide_nreset_o still low after reset", nreset);
    check_cond("strobes or chip selects low after reset", ndior && ndiow && ncs1fx && ncs3fx);
    check_cond("wb_ack_o or wb_tgc_o high after reset", !wb_ack && !wb_tgc);
    end_test("reset state", t0);

    // a word access always has da[0] low
    t0 = errors;
    for (int i = 0; i < 4; i++)
    begin
      words[i] = 16'($random(seed));
      a        = '0;
      a[8:3]   = 6'($random(seed));
      a[2:1]   = 2'(i);
      bus_cycle(1'b1, a, 2'b11, words[i], rd);
      check_cond("word write acknowledged at the wrong cycle", last_latency == PIO_LATENCY);
    end
    for (int i = 0; i < 4; i++)
    begin
      a      = '0;
      a[2:1] = 2'(i);
      bus_cycle(1'b0, a, 2'b11, 16'h0000, rd);
      check_eq("command register word", rd, words[i]);
      check_cond("word access with da[0] high", last_da == {2'(i), 1'b0});
      check_cond("command access with ncs3fx low", !last_cs3);
    end
    end_test("command block words", t0);

    // byte lanes
    t0     = errors;
    wr     = 16'($random(seed));
    a      = '0;
    a[2:1] = 2'b01;
    bus_cycle(1'b1, a, 2'b01, wr, rd);
    check_cond("low byte write with da[0] high", last_da == 3'b010);
    bus_cycle(1'b0, a, 2'b11, 16'h0000, rd);
    check_eq("low byte write, word readback", rd, {8'h00, wr[7:0]});
    bus_cycle(1'b0, a, 2'b01, 16'h0000, rd);
    check_eq("low lane read", rd, {8'h00, wr[7:0]});
    bus_cycle(1'b1, a, 2'b10, wr, rd);
    check_cond("high byte write with da[0] low", last_da == 3'b011);
    bus_cycle(1'b0, a, 2'b10, 16'h0000, rd);
    check_eq("high lane read", rd, {wr[15:8], 8'h00});
    end_test("byte lanes", t0);

    // control block and unmapped space
    t0     = errors;
    wr     = 16'($random(seed));
    a      = '0;
    a[9]   = 1'b1;
    a[2:1] = 2'b11;
    bus_cycle(1'b1, a, 2'b11, wr, rd);
    check_cond("control write without ncs3fx", last_cs3);
    bus_cycle(1'b0, a, 2'b11, 16'h0000, rd);
    check_cond("control read without ncs3fx", last_cs3);
    check_eq("control register", rd, wr);
    // read first so wb_dat_o still holds the control data
    n      = strobe_cnt;
    a[2:1] = 2'b01;
    bus_cycle(1'b0, a, 2'b11, 16'h0000, rd);
    check_eq("unmapped read", rd, 16'h0000);
    check_cond("unmapped read not acknowledged at once", last_latency == 1);
    bus_cycle(1'b1, a, 2'b11, wr, rd);
    check_cond("unmapped write not acknowledged at once", last_latency == 1);
    check_cond("unmapped access produced a strobe", strobe_cnt == n);
    end_test("control and unmapped", t0);

    // iordy stretch
    t0 = errors;
    for (int i = 0; i < 8; i++)
    begin
      dev_wait = 3'($random(seed));
      wr       = 16'($random(seed));
      a        = '0;
      a[2:1]   = 2'(i);
      bus_cycle(1'b1, a, 2'b11, wr, rd);
      check_cond("write strobe too short for the iordy wait",
                 last_width >= MIN_STROBE_CYCLES && last_width >= int'(dev_wait) + 1);
      bus_cycle(1'b0, a, 2'b11, 16'h0000, rd);
      check_eq("read under iordy wait", rd, wr);
      check_cond("read strobe too short for the iordy wait",
                 last_width >= MIN_STROBE_CYCLES && last_width >= int'(dev_wait) + 1);
    end
    dev_wait = 3'd0;
    end_test("iordy stretch", t0);

    // interrupt through the two flop synchronizer
    t0        = errors;
    dev_intrq = 1'b1;
    @(posedge clk);
    #1;
    check_cond("wb_tgc_o rose one cycle after intrq", !wb_tgc);
    @(posedge clk);
    #1;
    check_cond("wb_tgc_o not high two cycles after intrq", wb_tgc);
    dev_intrq = 1'b0;
    @(posedge clk);
    #1;
    check_cond("wb_tgc_o fell one cycle after intrq", wb_tgc);
    @(posedge clk);
    #1;
    check_cond("wb_tgc_o not low two cycles after intrq", !wb_tgc);
    end_test("interrupt", t0);

    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, u_dut.u_props.fail_cnt);
    if (errors == 0 && tests_failed == 0 && u_dut.u_props.fail_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
verilog/ide_pkg.sv
verilog/ide_wb_host.sv
verilog/ide_pio_sequencer.sv
verilog/ide_ctrl_top.sv
testbench/tb_clk_gen.sv
testbench/ata_device_model.sv
testbench/ide_ctrl_properties.sv
testbench/tb_ide_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_ide_ctrl
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
# keep running past assertion errors so the summary is printed
SIM_ARGS  := +verilator+error+limit+1000
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
